//--- design/vip_pkg.sv
// Package vip_pkg with image size, pixel type, stage latencies and luma weights
package vip_pkg;

	// ----------------------------------------
	// Pixel and image geometry
	typedef logic [7:0] pix_t;                       // One grey value or colour channel

	localparam int img_hdisp = 64;                   // Active pixels per line
	localparam int img_vdisp = 16;                   // Active lines per frame

	localparam int col_w = $clog2(img_hdisp);        // Column counter width
	localparam int row_w = $clog2(img_vdisp);        // Row counter width

	// ----------------------------------------
	// Stage latencies in clocks
	localparam int lat_demosaic = 1;                 // RAW in to RGB out
	localparam int lat_gray     = 2;                 // Products, then sum
	localparam int lat_median   = 3;                 // Row sort, column pick, final median
	localparam int lat_total    = lat_demosaic + lat_gray + lat_median;

	// ----------------------------------------
	// Luma weights, sum is 256 so a shift by 8 normalises
	localparam int luma_wr = 77;
	localparam int luma_wg = 150;
	localparam int luma_wb = 29;

endpackage

//--- design/vip_line_buffer.sv
// Module vip_line_buffer, one line of delay for 8-bit pixels
`timescale 1ns/1ps

module vip_line_buffer import vip_pkg::*; (
	input  logic clk,                                // Pixel clock
	input  logic arst_n,                             // Async reset, active low
	input  logic href,                               // Line valid
	input  pix_t din,                                // Pixel of the current line
	output pix_t dout                                // Same column, one line earlier
);

	pix_t             mem [img_hdisp];               // One full line of pixels
	logic [col_w-1:0] ptr;                           // Column pointer

	// Read before write, so dout holds last line's pixel at this column
	assign dout = mem[ptr];

	always_ff @(posedge clk) begin
		if (href) begin
			mem[ptr] <= din;                         // Overwrite after the read
		end
	end

	// Pointer follows the column, back to zero once href drops
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ptr <= '0;
		end else if (href) begin
			ptr <= (ptr == col_w'(img_hdisp - 1)) ? '0 : ptr + 1'b1;
		end else begin
			ptr <= '0;
		end
	end

	// ----------------------------------------
	// A line may not outrun the buffer
	a_ptr_in_range: assert property (@(posedge clk) disable iff (!arst_n)
		href && ptr == col_w'(img_hdisp - 1) |=> !href)
		else $error("line longer than img_hdisp");

endmodule

//--- design/vip_bayer_demosaic.sv
// Module vip_bayer_demosaic, RAW8 RGGB to RGB888 from a causal 2x2 quad
`timescale 1ns/1ps

module vip_bayer_demosaic import vip_pkg::*; (
	input  logic clk,                                // Pixel clock
	input  logic arst_n,                             // Async reset, active low
	input  logic vsync,                              // Frame start
	input  logic href,                               // Pixel valid
	input  pix_t raw,                                // RAW8 sample
	output logic post_vsync,                         // vsync, one clock later
	output logic post_href,                          // href, one clock later
	output pix_t red,
	output pix_t green,
	output pix_t blue
);

	logic [col_w-1:0] col;                           // Column of the incoming pixel
	logic [row_w-1:0] row;                           // Row of the incoming pixel
	pix_t             lb_dout;                       // (r-1, c)
	pix_t             cur_prev;                      // (r, c-1), ungated
	pix_t             up_prev;                       // (r-1, c-1), ungated
	pix_t             p00, p01, p10, p11;            // Gated quad, p<row><col>
	pix_t             r_sel, b_sel, g_a, g_b;
	logic [8:0]       g_sum;                         // Green pair sum, one extra bit

	vip_line_buffer u_line_buffer (
		.clk    (clk),
		.arst_n (arst_n),
		.href   (href),
		.din    (raw),
		.dout   (lb_dout)
	);

	// ----------------------------------------
	// Position counters and framing delay
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			col        <= '0;
			row        <= '0;
			post_vsync <= 1'b0;
			post_href  <= 1'b0;
		end else begin
			post_vsync <= vsync;
			post_href  <= href;                      // Also last href for the edge below
			if (href) begin
				col <= (col == col_w'(img_hdisp - 1)) ? '0 : col + 1'b1;
			end else begin
				col <= '0;
			end
			if (vsync) begin
				row <= '0;                           // New frame
			end else if (post_href && !href) begin
				row <= row + 1'b1;                   // End of line
			end
		end
	end

	// Left neighbours of both rows
	always_ff @(posedge clk) begin
		if (href) begin
			cur_prev <= raw;
			up_prev  <= lb_dout;
		end
	end

	// ----------------------------------------
	// Quad taps with zero outside the frame, then pick by parity
	always_comb begin
		p11 = raw;
		p10 = (col != '0) ? cur_prev : '0;
		p01 = (row != '0) ? lb_dout : '0;
		p00 = (col != '0 && row != '0) ? up_prev : '0;
		case ({row[0], col[0]})
			2'b00: begin                             // Red at (r, c)
				r_sel = p11;
				b_sel = p00;
				g_a   = p10;
				g_b   = p01;
			end
			2'b01: begin                             // Red at (r, c-1)
				r_sel = p10;
				b_sel = p01;
				g_a   = p11;
				g_b   = p00;
			end
			2'b10: begin                             // Red at (r-1, c)
				r_sel = p01;
				b_sel = p10;
				g_a   = p11;
				g_b   = p00;
			end
			default: begin                           // Blue at (r, c)
				r_sel = p00;
				b_sel = p11;
				g_a   = p10;
				g_b   = p01;
			end
		endcase
	end

	assign g_sum = {1'b0, g_a} + {1'b0, g_b};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
		end else if (href) begin
			red   <= r_sel;
			green <= g_sum[8:1];                     // Truncated mean
			blue  <= b_sel;
		end
	end

endmodule

//--- design/vip_rgb_to_gray.sv
// Module vip_rgb_to_gray, two-stage weighted sum giving 8-bit luma
`timescale 1ns/1ps

module vip_rgb_to_gray import vip_pkg::*; (
	input  logic clk,                                // Pixel clock
	input  logic arst_n,                             // Async reset, active low
	input  logic vsync,
	input  logic href,
	input  pix_t red,
	input  pix_t green,
	input  pix_t blue,
	output logic post_vsync,
	output logic post_href,
	output pix_t gray                                // Luma, Y only
);

	logic [lat_gray-1:0] vs_d, hr_d;                 // Framing delay line
	logic [15:0]         prod_r, prod_g, prod_b;     // Stage 1 products
	logic [15:0]         sum;                        // Max 255*256, fits 16 bits

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vs_d <= '0;
			hr_d <= '0;
		end else begin
			vs_d <= {vs_d[lat_gray-2:0], vsync};
			hr_d <= {hr_d[lat_gray-2:0], href};
		end
	end

	// Stage 1
	always_ff @(posedge clk) begin
		if (href) begin
			prod_r <= 16'(red) * 16'(luma_wr);
			prod_g <= 16'(green) * 16'(luma_wg);
			prod_b <= 16'(blue) * 16'(luma_wb);
		end
	end

	assign sum = prod_r + prod_g + prod_b;

	// Stage 2, drop the weight scale
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gray <= '0;
		end else if (hr_d[0]) begin
			gray <= sum[15:8];
		end
	end

	assign post_vsync = vs_d[lat_gray-1];
	assign post_href  = hr_d[lat_gray-1];

endmodule

//--- design/vip_median3x3.sv
// Module vip_median3x3, 3x3 window over two line buffers and a pipelined median
`timescale 1ns/1ps

module vip_median3x3 import vip_pkg::*; (
	input  logic clk,                                // Pixel clock
	input  logic arst_n,                             // Async reset, active low
	input  logic vsync,
	input  logic href,
	input  pix_t gray,
	output logic post_vsync,
	output logic post_href,
	output pix_t gray_med                            // Median of the 3x3 window
);

	logic [lat_median-1:0] vs_d, hr_d;               // Framing delay, one bit per stage
	logic [col_w-1:0]      col;
	logic [row_w-1:0]      row;                      // Saturates on the last line
	pix_t                  lb1_dout, lb2_dout;       // (r-1, c) and (r-2, c)
	pix_t                  tap [3];                  // Column c, index 0 is row r-2
	pix_t                  prev1 [3];                // Column c-1
	pix_t                  prev2 [3];                // Column c-2
	pix_t                  win [3][3];               // Gated window [row][col]
	pix_t                  row_lo [3], row_md [3], row_hi [3];
	pix_t                  lo_max, md_med, hi_min;

	function automatic pix_t max2(input pix_t a, input pix_t b);
		return (a > b) ? a : b;
	endfunction

	function automatic pix_t min2(input pix_t a, input pix_t b);
		return (a > b) ? b : a;
	endfunction

	function automatic pix_t max3(input pix_t a, input pix_t b, input pix_t c);
		return max2(max2(a, b), c);
	endfunction

	function automatic pix_t min3(input pix_t a, input pix_t b, input pix_t c);
		return min2(min2(a, b), c);
	endfunction

	function automatic pix_t med3(input pix_t a, input pix_t b, input pix_t c);
		return max2(min2(a, b), min2(max2(a, b), c));
	endfunction

	// Chained line buffers, two lines of history
	vip_line_buffer u_line_buffer_0 (
		.clk    (clk),
		.arst_n (arst_n),
		.href   (href),
		.din    (gray),
		.dout   (lb1_dout)
	);

	vip_line_buffer u_line_buffer_1 (
		.clk    (clk),
		.arst_n (arst_n),
		.href   (href),
		.din    (lb1_dout),
		.dout   (lb2_dout)
	);

	// ----------------------------------------
	// Framing delay and position counters
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vs_d <= '0;
			hr_d <= '0;
			col  <= '0;
			row  <= '0;
		end else begin
			vs_d <= {vs_d[lat_median-2:0], vsync};
			hr_d <= {hr_d[lat_median-2:0], href};
			if (href) begin
				col <= (col == col_w'(img_hdisp - 1)) ? '0 : col + 1'b1;
			end else begin
				col <= '0;
			end
			if (vsync) begin
				row <= '0;
			end else if (hr_d[0] && !href && row != row_w'(img_vdisp - 1)) begin
				row <= row + 1'b1;
			end
		end
	end

	// Zero padding above and to the left
	always_comb begin
		tap[0] = (row >= row_w'(2)) ? lb2_dout : '0;
		tap[1] = (row != '0) ? lb1_dout : '0;
		tap[2] = gray;
		for (int k = 0; k < 3; k++) begin
			win[k][2] = tap[k];
			win[k][1] = (col != '0) ? prev1[k] : '0;
			win[k][0] = (col >= col_w'(2)) ? prev2[k] : '0;
		end
	end

	// ----------------------------------------
	// Window shift, stage 1 row sort, stage 2 column pick
	always_ff @(posedge clk) begin
		if (href) begin
			for (int k = 0; k < 3; k++) begin
				prev2[k]  <= prev1[k];
				prev1[k]  <= tap[k];
				row_lo[k] <= min3(win[k][0], win[k][1], win[k][2]);
				row_md[k] <= med3(win[k][0], win[k][1], win[k][2]);
				row_hi[k] <= max3(win[k][0], win[k][1], win[k][2]);
			end
		end
		if (hr_d[0]) begin
			lo_max <= max3(row_lo[0], row_lo[1], row_lo[2]);
			md_med <= med3(row_md[0], row_md[1], row_md[2]);
			hi_min <= min3(row_hi[0], row_hi[1], row_hi[2]);
		end
	end

	// Stage 3, median of the three survivors
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gray_med <= '0;
		end else if (hr_d[1]) begin
			gray_med <= med3(lo_max, md_med, hi_min);
		end
	end

	assign post_vsync = vs_d[lat_median-1];
	assign post_href  = hr_d[lat_median-1];

	// Upstream framing keeps vsync and active pixels apart
	a_no_href_in_vsync: assert property (@(posedge clk) disable iff (!arst_n)
		!(href && vsync))
		else $error("href high during vsync");

endmodule

//--- design/vip_image_processor.sv
// Module vip_image_processor, RAW to grey pipeline of demosaic, luma and median
`timescale 1ns/1ps

module vip_image_processor import vip_pkg::*; (
	input  logic clk,                                // Sensor pixel clock
	input  logic arst_n,                             // Async reset, active low
	input  logic vsync,
	input  logic href,
	input  pix_t raw,                                // RAW8 RGGB
	output logic post_vsync,
	output logic post_href,
	output pix_t gray                                // Filtered grey, lat_total clocks later
);

	// ----------------------------------------
	// Stage 1, RAW to RGB888
	logic post1_vsync, post1_href;
	pix_t post1_red, post1_green, post1_blue;

	vip_bayer_demosaic u_vip_bayer_demosaic (
		.clk        (clk),
		.arst_n     (arst_n),
		.vsync      (vsync),
		.href       (href),
		.raw        (raw),
		.post_vsync (post1_vsync),
		.post_href  (post1_href),
		.red        (post1_red),
		.green      (post1_green),
		.blue       (post1_blue)
	);

	// ----------------------------------------
	// Stage 2, RGB to luma
	logic post2_vsync, post2_href;
	pix_t post2_gray;

	vip_rgb_to_gray u_vip_rgb_to_gray (
		.clk        (clk),
		.arst_n     (arst_n),
		.vsync      (post1_vsync),
		.href       (post1_href),
		.red        (post1_red),
		.green      (post1_green),
		.blue       (post1_blue),
		.post_vsync (post2_vsync),
		.post_href  (post2_href),
		.gray       (post2_gray)
	);

	// ----------------------------------------
	// Stage 3, 3x3 median on grey
	vip_median3x3 u_vip_median3x3 (
		.clk        (clk),
		.arst_n     (arst_n),
		.vsync      (post2_vsync),
		.href       (post2_href),
		.gray       (post2_gray),
		.post_vsync (post_vsync),
		.post_href  (post_href),
		.gray_med   (gray)
	);

	// End to end framing is a pure delay of the input
	a_total_latency: assert property (@(posedge clk) disable iff (!arst_n)
		post_href == $past(href, lat_total))
		else $error("post_href is not href delayed by lat_total");

endmodule

//--- include/vip_tb_model.svh
// Reference model storage and functions for demosaic, luma and 3x3 median over one frame
`ifndef VIP_TB_MODEL_SVH
`define VIP_TB_MODEL_SVH

pix_t mdl_raw  [img_vdisp][img_hdisp];              // Stored RAW frame
pix_t mdl_gray [img_vdisp][img_hdisp];              // Luma grid
pix_t mdl_med  [img_vdisp][img_hdisp];              // Expected DUT output

// Zero outside the frame
function automatic pix_t mdl_raw_at(input int r, input int c);
	if (r < 0 || c < 0 || r >= img_vdisp || c >= img_hdisp)
		return '0;
	return mdl_raw[r][c];
endfunction

function automatic pix_t mdl_gray_at(input int r, input int c);
	if (r < 0 || c < 0 || r >= img_vdisp || c >= img_hdisp)
		return '0;
	return mdl_gray[r][c];
endfunction

function automatic pix_t mdl_luma(input pix_t red, input pix_t green, input pix_t blue);
	int sum;
	sum = luma_wr * red + luma_wg * green + luma_wb * blue;
	return pix_t'(sum >> 8);
endfunction

// Each member of rows r-1..r and columns c-1..c placed by its own parity
function automatic pix_t mdl_demosaic_gray(input int r, input int c);
	int red;
	int blue;
	int gsum;
	int v;
	red  = 0;
	blue = 0;
	gsum = 0;
	for (int qr = r - 1; qr <= r; qr++) begin
		for (int qc = c - 1; qc <= c; qc++) begin
			v = mdl_raw_at(qr, qc);
			if (qr % 2 == 0 && qc % 2 == 0)
				red = v;                            // Even row, even column
			else if (qr % 2 != 0 && qc % 2 != 0)
				blue = v;                           // Odd row, odd column
			else
				gsum += v;                          // The two greens
		end
	end
	return mdl_luma(pix_t'(red), pix_t'(gsum / 2), pix_t'(blue));
endfunction

// True median by sorting all nine values
function automatic pix_t mdl_median(input int r, input int c);
	pix_t v [9];
	pix_t t;
	for (int i = 0; i < 9; i++)
		v[i] = mdl_gray_at(r - 2 + i / 3, c - 2 + i % 3);
	for (int i = 0; i < 8; i++) begin
		for (int j = 0; j < 8 - i; j++) begin
			if (v[j] > v[j + 1]) begin
				t        = v[j];
				v[j]     = v[j + 1];
				v[j + 1] = t;
			end
		end
	end
	return v[4];
endfunction

// Fill both grids from mdl_raw
task automatic mdl_compute();
	for (int r = 0; r < img_vdisp; r++)
		for (int c = 0; c < img_hdisp; c++)
			mdl_gray[r][c] = mdl_demosaic_gray(r, c);
	for (int r = 0; r < img_vdisp; r++)
		for (int c = 0; c < img_hdisp; c++)
			mdl_med[r][c] = mdl_median(r, c);
endtask

`endif

//--- tests/tb_vip_image_processor.sv
// Testbench tb_vip_image_processor with clock, reset, random frames, capture, compare tasks, watchdog
`timescale 1ns/1ps

module tb_vip_image_processor import vip_pkg::*; ();

	logic clk;
	logic arst_n;
	logic vsync;
	logic href;
	pix_t raw;
	logic post_vsync;
	logic post_href;
	pix_t gray;

	logic [31:0]          lcg_state;                  // Random generator state
	int                   test_errs [6];              // Errors per test, index is test number
	int                   n_checks;
	int                   cur_test;                   // Test that owns the captured pixels
	int                   cap_count;                  // Output pixels of the current frame
	logic                 flat_chk;                   // Interior must equal flat_v
	pix_t                 flat_v;
	logic [lat_total-1:0] href_hist = '0;             // Input href, one bit per clock back
	logic [lat_total-1:0] vsync_hist = '0;

	vip_image_processor u_vip_image_processor (
		.clk        (clk),
		.arst_n     (arst_n),
		.vsync      (vsync),
		.href       (href),
		.raw        (raw),
		.post_vsync (post_vsync),
		.post_href  (post_href),
		.gray       (gray)
	);

	`include "vip_tb_model.svh"

	// ----------------------------------------
	// Random numbers, compare tasks, report
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] v;
		v = lcg_next();
		return lo + int'({16'b0, v[31:16]}) % (hi - lo + 1);   // Upper bits are the better ones
	endfunction

	task automatic check_pix(input int id, input string name, input pix_t got, input pix_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
			test_errs[id]++;
		end
	endtask

	task automatic check_bit(input int id, input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			test_errs[id]++;
		end
	endtask

	task automatic report_test(input int id, input string name);
		$display("test %0d %s: %0d errors", id, name, test_errs[id]);
	endtask

	// ----------------------------------------
	// Frame fill and drive
	task automatic step_clk();
		@(posedge clk);
		#1;                                           // Inputs settle after the edge
	endtask

	task automatic fill_random();
		for (int r = 0; r < img_vdisp; r++)
			for (int c = 0; c < img_hdisp; c++)
				mdl_raw[r][c] = pix_t'(lcg_next() >> 24);
		mdl_compute();
	endtask

	task automatic fill_uniform(input pix_t v);
		for (int r = 0; r < img_vdisp; r++)
			for (int c = 0; c < img_hdisp; c++)
				mdl_raw[r][c] = v;
		mdl_compute();
	endtask

	// Spikes six apart, so no median window sees two of them
	task automatic fill_spikes(input pix_t base);
		for (int r = 0; r < img_vdisp; r++)
			for (int c = 0; c < img_hdisp; c++)
				mdl_raw[r][c] = (r % 6 == 2 && c % 6 == 2) ? pix_t'(rand_range(200, 255)) : base;
		mdl_compute();
	endtask

	task automatic run_frame();
		repeat (rand_range(10, 29)) step_clk();       // Vertical blanking
		step_clk();
		vsync = 1'b1;
		step_clk();
		vsync = 1'b0;
		repeat (rand_range(2, 9)) step_clk();
		for (int r = 0; r < img_vdisp; r++) begin
			for (int c = 0; c < img_hdisp; c++) begin
				step_clk();
				href = 1'b1;
				raw  = mdl_raw[r][c];
			end
			step_clk();
			href = 1'b0;
			raw  = '0;
			repeat (rand_range(2, 9) - 1) step_clk(); // Horizontal blanking
		end
		wait (cap_count == img_hdisp * img_vdisp);    // All pixels out, watchdog guards
	endtask

	// ----------------------------------------
	// Clock, framing monitor and output capture
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;                        // 4 ns period
	end

	// Mid-cycle sampling, outputs are stable here
	always @(negedge clk) begin : capture
		int r;
		int c;
		if (arst_n) begin
			check_bit(2, "post_href", post_href, href_hist[lat_total-1]);
			check_bit(2, "post_vsync", post_vsync, vsync_hist[lat_total-1]);
			if (post_vsync)
				cap_count = 0;                        // New output frame
			if (post_href) begin
				r = cap_count / img_hdisp;
				c = cap_count % img_hdisp;
				if (cap_count >= img_hdisp * img_vdisp) begin
					$display("Output pixel beyond the end of the frame at %0t", $time);
					test_errs[cur_test]++;
				end else begin
					check_pix(cur_test, $sformatf("gray[%0d][%0d]", r, c), gray, mdl_med[r][c]);
					if (flat_chk && r >= 3 && c >= 3)   // Window fully inside the flat area
						check_pix(cur_test, $sformatf("gray[%0d][%0d]", r, c), gray, flat_v);
				end
				cap_count++;
			end
		end
		href_hist  = {href_hist[lat_total-2:0], href};
		vsync_hist = {vsync_hist[lat_total-2:0], vsync};
	end

	// Five frames at worst-case blanking, plus reset and a margin
	initial begin : watchdog
		longint frame_clks;
		longint limit_clks;
		frame_clks = 30 + 2 + 9 + img_vdisp * (img_hdisp + 9) + lat_total;
		limit_clks = 16 + 5 * frame_clks + 200;
		#(limit_clks * 4);
		$display("Timeout, the DUT did not deliver every output pixel in time");
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ----------------------------------------
	// Test sequence
	initial begin : main
		int total_errs;
		lcg_state = 32'hb1b2;
		arst_n    = 1'b0;
		vsync     = 1'b0;
		href      = 1'b0;
		raw       = '0;
		cur_test  = 1;
		cap_count = 0;
		n_checks  = 0;
		flat_chk  = 1'b0;
		flat_v    = '0;
		repeat (16) @(posedge clk);
		#1 arst_n = 1'b1;

		repeat (3) @(negedge clk);                    // Idle, nothing driven yet
		check_bit(1, "post_vsync", post_vsync, 1'b0);
		check_bit(1, "post_href", post_href, 1'b0);
		check_pix(1, "gray", gray, '0);
		report_test(1, "reset state");

		cur_test = 3;
		flat_v   = pix_t'(rand_range(0, 255));
		flat_chk = 1'b1;
		fill_uniform(flat_v);
		run_frame();
		report_test(3, "uniform frame");

		cur_test = 4;
		flat_chk = 1'b0;
		for (int f = 0; f < 3; f++) begin
			fill_random();
			run_frame();
		end
		report_test(4, "random frames");

		cur_test = 5;
		flat_v   = pix_t'(rand_range(0, 99));         // Base well below the spikes
		flat_chk = 1'b1;
		fill_spikes(flat_v);
		run_frame();
		report_test(5, "isolated spikes");

		repeat (lat_total + 4) step_clk();            // Let the framing monitor drain
		report_test(2, "framing delay");

		total_errs = 0;
		foreach (test_errs[i])
			total_errs += test_errs[i];
		$display("%0d checks, %0d errors", n_checks, total_errs);
		if (total_errs == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- flist.f
+incdir+include
design/vip_pkg.sv
design/vip_line_buffer.sv
design/vip_bayer_demosaic.sv
design/vip_rgb_to_gray.sv
design/vip_median3x3.sv
design/vip_image_processor.sv
tests/tb_vip_image_processor.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f flist.f --top-module tb_vip_image_processor \
	--Mdir obj_dir -o vtb > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/vtb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
	exit 1
fi
exit 0
